/* hdl/cpuPkg.sv */
//####################
// cpu package
// opcodes, alu operations, widths and host address map
//####################
`default_nettype none

package cpuPkg;

	// datapath and field widths
	localparam int dataW = 64;
	localparam int instW = 32;
	localparam int regAddrW = 5;
	localparam int hostAdrW = 10;

	// opcode field inst[31:21], short opcodes padded with zeros on the right
	typedef enum logic [10:0] {
		opAdd  = 11'b10001011000,
		opSub  = 11'b11001011000,
		opAnd  = 11'b10001010000,
		opOrr  = 11'b10101010000,
		// i-type, top 10 bits significant
		opAddi = 11'b10010001000,
		opSubi = 11'b11010001000,
		opLdur = 11'b11111000010,
		opStur = 11'b11111000000,
		// cb-type, top 8 bits significant
		opCbz  = 11'b10110100000,
		// b-type, top 6 bits significant
		opB    = 11'b00010100000
	} opcodeT;

	typedef enum logic [2:0] {
		aluAdd   = 3'd0,
		aluSub   = 3'd1,
		aluAnd   = 3'd2,
		aluOr    = 3'd3,
		aluPassB = 3'd4
	} aluOpT;

	// host regions, picked by the top two word-address bits
	localparam logic [1:0] regionImem = 2'b00;
	localparam logic [1:0] regionDmem = 2'b01;
	localparam logic [1:0] regionCsr  = 2'b10;
	// run control and status words
	localparam logic [hostAdrW-1:0] ctrlAdr = 10'h200;
	localparam logic [hostAdrW-1:0] statAdr = 10'h201;

endpackage

`default_nettype wire

/* hdl/programCounter.sv */
//####################
// program counter
// pc register with sequential and branch next-pc select
//####################
`timescale 1ns/10ps
`default_nettype none

module programCounter (
	input wire logic clk,
	input wire logic rstN,
	input wire logic run,
	input wire logic start,
	input wire logic uncondBr,
	input wire logic brTaken,
	input wire logic [18:0] condAddr19,
	input wire logic [25:0] brAddr26,
	output logic [cpuPkg::dataW-1:0] pc
);

	logic [cpuPkg::dataW-1:0] offset;
	logic [cpuPkg::dataW-1:0] nextPc;

	// word offsets, sign extended and scaled to bytes
	always_comb begin
		if (uncondBr) begin
			offset = {{(cpuPkg::dataW - 28){brAddr26[25]}}, brAddr26, 2'b00};
		end else begin
			offset = {{(cpuPkg::dataW - 21){condAddr19[18]}}, condAddr19, 2'b00};
		end
	end

	// a branch to itself keeps the pc where it is
	assign nextPc = (uncondBr || brTaken) ? pc + offset : pc + 64'd4;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
		end else if (start) begin
			// restart always from address zero
			pc <= '0;
		end else if (run) begin
			pc <= nextPc;
		end
	end

endmodule

`default_nettype wire

/* hdl/controlDecoder.sv */
//####################
// control decoder
// opcode to datapath controls, flags the halt branch
//####################
`timescale 1ns/10ps
`default_nettype none

module controlDecoder (
	input wire logic [cpuPkg::instW-1:0] inst,
	input wire logic aluZero,
	output logic reg2Loc,
	output logic aluSrc,
	output logic immZero,
	output logic memToReg,
	output logic regWrite,
	output logic memWrite,
	output logic uncondBr,
	output logic brTaken,
	output cpuPkg::aluOpT aluOp,
	output logic halt
);

	cpuPkg::opcodeT op;
	logic opValid;

	// match each opcode on its own significant bits
	always_comb begin
		opValid = 1'b1;
		op = cpuPkg::opAdd;
		if (inst[31:26] == 6'(cpuPkg::opB >> 5)) begin
			op = cpuPkg::opB;
		end else if (inst[31:24] == 8'(cpuPkg::opCbz >> 3)) begin
			op = cpuPkg::opCbz;
		end else if (inst[31:22] == 10'(cpuPkg::opAddi >> 1)) begin
			op = cpuPkg::opAddi;
		end else if (inst[31:22] == 10'(cpuPkg::opSubi >> 1)) begin
			op = cpuPkg::opSubi;
		end else begin
			case (inst[31:21])
				cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opOrr,
				cpuPkg::opLdur, cpuPkg::opStur: op = cpuPkg::opcodeT'(inst[31:21]);
				// unknown, runs as a nop
				default: opValid = 1'b0;
			endcase
		end
	end

	always_comb begin
		// nop defaults
		reg2Loc = 1'b0;
		aluSrc = 1'b0;
		immZero = 1'b0;
		memToReg = 1'b0;
		regWrite = 1'b0;
		memWrite = 1'b0;
		uncondBr = 1'b0;
		brTaken = 1'b0;
		aluOp = cpuPkg::aluAdd;
		halt = 1'b0;
		if (opValid) begin
			case (op)
				cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opOrr: begin
					// second operand from rm
					reg2Loc = 1'b1;
					regWrite = 1'b1;
					aluOp = (op == cpuPkg::opSub) ? cpuPkg::aluSub :
						(op == cpuPkg::opAnd) ? cpuPkg::aluAnd :
						(op == cpuPkg::opOrr) ? cpuPkg::aluOr : cpuPkg::aluAdd;
				end
				cpuPkg::opAddi, cpuPkg::opSubi: begin
					aluSrc = 1'b1;
					immZero = 1'b1;
					regWrite = 1'b1;
					aluOp = (op == cpuPkg::opSubi) ? cpuPkg::aluSub : cpuPkg::aluAdd;
				end
				cpuPkg::opLdur: begin
					aluSrc = 1'b1;
					memToReg = 1'b1;
					regWrite = 1'b1;
				end
				cpuPkg::opStur: begin
					// rd holds the store data
					aluSrc = 1'b1;
					memWrite = 1'b1;
				end
				cpuPkg::opCbz: begin
					// rt sits in the rd field, tested through passB
					aluOp = cpuPkg::aluPassB;
					brTaken = aluZero;
				end
				cpuPkg::opB: begin
					uncondBr = 1'b1;
					halt = (inst[25:0] == 26'd0);
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/regFile.sv */
//####################
// register file
// 32 x 64 with x31 fixed at zero
//####################
`timescale 1ns/10ps
`default_nettype none

module regFile (
	input wire logic clk,
	input wire logic rstN,
	input wire logic [cpuPkg::regAddrW-1:0] readReg1,
	input wire logic [cpuPkg::regAddrW-1:0] readReg2,
	input wire logic [cpuPkg::regAddrW-1:0] writeReg,
	input wire logic writeEn,
	input wire logic [cpuPkg::dataW-1:0] writeData,
	output logic [cpuPkg::dataW-1:0] readData1,
	output logic [cpuPkg::dataW-1:0] readData2
);

	// x0 to x30 only, x31 has no storage
	logic [cpuPkg::dataW-1:0] regs [31];

	assign readData1 = (readReg1 == 5'd31) ? '0 : regs[readReg1];
	assign readData2 = (readReg2 == 5'd31) ? '0 : regs[readReg2];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 31; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && writeReg != 5'd31) begin
			regs[writeReg] <= writeData;
		end
	end

endmodule

`default_nettype wire

/* hdl/alu.sv */
//####################
// alu
// add, sub, and, or, passB with zero flag
//####################
`timescale 1ns/10ps
`default_nettype none

module alu (
	input wire logic [cpuPkg::dataW-1:0] a,
	input wire logic [cpuPkg::dataW-1:0] b,
	input wire cpuPkg::aluOpT op,
	output logic [cpuPkg::dataW-1:0] result,
	output logic zero
);

	always_comb begin
		case (op)
			cpuPkg::aluAdd: begin
				result = a + b;
			end
			cpuPkg::aluSub: begin
				result = a - b;
			end
			cpuPkg::aluAnd: begin
				result = a & b;
			end
			cpuPkg::aluOr: begin
				result = a | b;
			end
			// cbz tests the register on b
			cpuPkg::aluPassB: begin
				result = b;
			end
			default: begin
				result = '0;
			end
		endcase
	end

	// only flag kept
	assign zero = (result == '0);

endmodule

`default_nettype wire

/* hdl/wordMemory.sv */
//####################
// word memory
// core port plus host port, host wins on hostSel
//####################
`timescale 1ns/10ps
`default_nettype none

module wordMemory #(
	parameter int depth = 256,
	parameter int width = 64
) (
	input wire logic clk,
	input wire logic [$clog2(depth)-1:0] coreAdr,
	input wire logic coreWe,
	input wire logic [width-1:0] coreDatW,
	output logic [width-1:0] coreDatR,
	input wire logic hostSel,
	input wire logic [$clog2(depth)-1:0] hostAdr,
	input wire logic hostWe,
	input wire logic [width-1:0] hostDatW,
	output logic [width-1:0] hostDatR
);

	// contents undefined until loaded
	logic [width-1:0] mem [depth];

	// core keeps reading even while host owns the memory
	assign coreDatR = mem[coreAdr];

	// host sees zeros while the core runs
	assign hostDatR = hostSel ? mem[hostAdr] : '0;

	always_ff @(posedge clk) begin
		if (hostSel) begin
			// core write blocked here
			if (hostWe) begin
				mem[hostAdr] <= hostDatW;
			end
		end else if (coreWe) begin
			mem[coreAdr] <= coreDatW;
		end
	end

endmodule

`default_nettype wire

/* hdl/cpuCore.sv */
//####################
// cpu core
// single-cycle legv8 datapath
//####################
`timescale 1ns/10ps
`default_nettype none

module cpuCore (
	input wire logic clk,
	input wire logic rstN,
	input wire logic run,
	input wire logic start,
	input wire logic [cpuPkg::instW-1:0] inst,
	output logic [cpuPkg::dataW-1:0] iAdr,
	output logic [cpuPkg::dataW-1:0] dAdr,
	output logic dWe,
	output logic [cpuPkg::dataW-1:0] dDatW,
	input wire logic [cpuPkg::dataW-1:0] dDatR,
	output logic halt,
	output logic [cpuPkg::dataW-1:0] pc
);

	// instruction fields
	logic [4:0] rn, rm, rd;
	logic [8:0] dAddr9;
	logic [11:0] imm12;
	// controls
	logic reg2Loc, aluSrc, immZero, memToReg, regWrite, memWrite;
	logic uncondBr, brTaken, aluZero;
	cpuPkg::aluOpT aluOp;
	// datapath
	logic [4:0] readReg2;
	logic [cpuPkg::dataW-1:0] rd1, rd2, immExt, aluB, aluOut, writeData;

	assign rn = inst[9:5];
	assign rm = inst[20:16];
	assign rd = inst[4:0];
	assign dAddr9 = inst[20:12];
	assign imm12 = inst[21:10];

	programCounter pc0 (.clk, .rstN, .run, .start, .uncondBr, .brTaken,
		.condAddr19(inst[23:5]), .brAddr26(inst[25:0]), .pc);

	controlDecoder dec0 (.inst, .aluZero, .reg2Loc, .aluSrc, .immZero, .memToReg,
		.regWrite, .memWrite, .uncondBr, .brTaken, .aluOp, .halt);

	// rm for r-type, rd for stur and cbz
	assign readReg2 = reg2Loc ? rm : rd;

	// register writes only while running
	regFile regs0 (.clk, .rstN, .readReg1(rn), .readReg2, .writeReg(rd),
		.writeEn(regWrite && run), .writeData, .readData1(rd1), .readData2(rd2));

	// zero-extended imm12 for addi/subi, sign-extended dAddr9 for ldur/stur
	assign immExt = immZero ? {{(cpuPkg::dataW - 12){1'b0}}, imm12} :
		{{(cpuPkg::dataW - 9){dAddr9[8]}}, dAddr9};
	assign aluB = aluSrc ? immExt : rd2;

	alu alu0 (.a(rd1), .b(aluB), .op(aluOp), .result(aluOut), .zero(aluZero));

	// memory side
	assign iAdr = pc;
	assign dAdr = aluOut;
	assign dDatW = rd2;
	assign dWe = memWrite && run;
	assign writeData = memToReg ? dDatR : aluOut;

endmodule

`default_nettype wire

/* hdl/hostRegs.sv */
//####################
// host registers
// wishbone slave, run control, status, memory decode
//####################
`timescale 1ns/10ps
`default_nettype none

module hostRegs (
	input wire logic clk,
	input wire logic rstN,
	input wire logic wbCyc,
	input wire logic wbStb,
	input wire logic wbWe,
	input wire logic [cpuPkg::hostAdrW-1:0] wbAdr,
	input wire logic [cpuPkg::dataW-1:0] wbDatW,
	output logic [cpuPkg::dataW-1:0] wbDatR,
	output logic wbAck,
	input wire logic halt,
	input wire logic [cpuPkg::dataW-1:0] pc,
	output logic run,
	output logic start,
	output logic hostSel,
	output logic [cpuPkg::hostAdrW-3:0] hostAdr,
	output logic hostWe,
	output logic [cpuPkg::dataW-1:0] hostDatW,
	output logic imemWe,
	output logic dmemWe,
	input wire logic [cpuPkg::instW-1:0] imemHostDat,
	input wire logic [cpuPkg::dataW-1:0] dmemHostDat
);

	logic [1:0] region;
	logic req;
	logic halted;
	logic ctrlWr;
	logic [cpuPkg::dataW-1:0] readMux;

	assign region = wbAdr[cpuPkg::hostAdrW-1 -: 2];
	// new access, not the cycle that is already acking
	assign req = wbCyc && wbStb && !wbAck;
	assign ctrlWr = req && wbWe && (wbAdr == cpuPkg::ctrlAdr);

	// memories belong to the host whenever the core is stopped
	assign hostSel = !run;
	assign hostAdr = wbAdr[cpuPkg::hostAdrW-3:0];
	assign hostDatW = wbDatW;
	// writes while running are acked but dropped
	assign hostWe = req && wbWe && hostSel;
	assign imemWe = hostWe && (region == cpuPkg::regionImem);
	assign dmemWe = hostWe && (region == cpuPkg::regionDmem);

	always_comb begin
		readMux = '0;
		case (region)
			cpuPkg::regionImem: readMux = {{(cpuPkg::dataW - cpuPkg::instW){1'b0}}, imemHostDat};
			cpuPkg::regionDmem: readMux = dmemHostDat;
			cpuPkg::regionCsr: begin
				// status: pc in the upper word, halted and running in bits 1:0
				if (wbAdr == cpuPkg::statAdr) begin
					readMux = {pc[31:0], {(cpuPkg::dataW - 34){1'b0}}, halted, run};
				end else if (wbAdr == cpuPkg::ctrlAdr) begin
					readMux = {{(cpuPkg::dataW - 1){1'b0}}, run};
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wbAck <= 1'b0;
			run <= 1'b0;
			start <= 1'b0;
			halted <= 1'b0;
		end else begin
			// one-cycle ack after the strobe is sampled
			wbAck <= req;
			start <= 1'b0;
			if (start) begin
				run <= 1'b1;
				halted <= 1'b0;
			end else if (run && halt) begin
				// pc stays on the branch-to-self
				run <= 1'b0;
				halted <= 1'b1;
			end
			if (ctrlWr) begin
				if (wbDatW[0] && !run && !start) begin
					start <= 1'b1;
				end else if (!wbDatW[0]) begin
					run <= 1'b0;
				end
			end
		end
	end

	// read data lands together with the ack
	always_ff @(posedge clk) begin
		if (req && !wbWe) begin
			wbDatR <= readMux;
		end
	end

endmodule

`default_nettype wire

/* hdl/cpuTop.sv */
//####################
// cpu top
// core, host registers and both memories
//####################
`timescale 1ns/10ps
`default_nettype none

module cpuTop #(
	parameter int imemDepth = 256,
	parameter int dmemDepth = 256
) (
	input wire logic clk,
	input wire logic rstN,
	input wire logic wbCyc,
	input wire logic wbStb,
	input wire logic wbWe,
	input wire logic [cpuPkg::hostAdrW-1:0] wbAdr,
	input wire logic [cpuPkg::dataW-1:0] wbDatW,
	output logic [cpuPkg::dataW-1:0] wbDatR,
	output logic wbAck
);

	localparam int imemAdrW = $clog2(imemDepth);
	localparam int dmemAdrW = $clog2(dmemDepth);

	// host side
	logic run, start, hostSel, imemWe, dmemWe;
	logic [cpuPkg::hostAdrW-3:0] hostAdr;
	logic [cpuPkg::dataW-1:0] hostDatW, dmemHostDat;
	logic [cpuPkg::instW-1:0] imemHostDat;
	// core side
	logic halt, dWe;
	logic [cpuPkg::dataW-1:0] pc, iAdr, dAdr, dDatW, dDatR;
	logic [cpuPkg::instW-1:0] inst;

	// hostWe is folded into the per-memory strobes
	hostRegs host0 (.clk, .rstN, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW, .wbDatR, .wbAck,
		.halt, .pc, .run, .start, .hostSel, .hostAdr, .hostWe(), .hostDatW,
		.imemWe, .dmemWe, .imemHostDat, .dmemHostDat);

	cpuCore core0 (.clk, .rstN, .run, .start, .inst, .iAdr, .dAdr, .dWe, .dDatW,
		.dDatR, .halt, .pc);

	// word index from byte address, 4-byte instructions
	wordMemory #(.depth(imemDepth), .width(cpuPkg::instW)) imem0 (.clk,
		.coreAdr(iAdr[2 +: imemAdrW]), .coreWe(1'b0), .coreDatW('0), .coreDatR(inst),
		.hostSel, .hostAdr(hostAdr[imemAdrW-1:0]), .hostWe(imemWe),
		.hostDatW(hostDatW[cpuPkg::instW-1:0]), .hostDatR(imemHostDat));

	// 8-byte data words
	wordMemory #(.depth(dmemDepth), .width(cpuPkg::dataW)) dmem0 (.clk,
		.coreAdr(dAdr[3 +: dmemAdrW]), .coreWe(dWe), .coreDatW(dDatW), .coreDatR(dDatR),
		.hostSel, .hostAdr(hostAdr[dmemAdrW-1:0]), .hostWe(dmemWe),
		.hostDatW, .hostDatR(dmemHostDat));

endmodule

`default_nettype wire

/* sim/cpuCore_sva.sv */
//####################
// cpu assertions
// wishbone ack timing and run control checks
//####################
`timescale 1ns/10ps
`default_nettype none

module cpuCore_sva (
	input wire logic clk,
	input wire logic rstN,
	input wire logic wbCyc,
	input wire logic wbStb,
	input wire logic wbAck,
	input wire logic run,
	input wire logic start,
	input wire logic halted,
	input wire logic dWe
);

	// new strobe gets its ack on the next edge
	ackFollowsStrobe: assert property (@(posedge clk) disable iff (!rstN)
		(wbCyc && wbStb && !wbAck) |=> wbAck)
		else $error("wishbone ack missing one cycle after strobe");

	// single-cycle ack
	ackOneCycle: assert property (@(posedge clk) disable iff (!rstN)
		wbAck |=> !wbAck)
		else $error("wishbone ack held longer than one cycle");

	// no ack without a request
	ackNeedsStrobe: assert property (@(posedge clk) disable iff (!rstN)
		$rose(wbAck) |-> $past(wbCyc && wbStb))
		else $error("wishbone ack without a strobe");

	startWhileStopped: assert property (@(posedge clk) disable iff (!rstN)
		start |-> !run)
		else $error("start pulse while the core is running");

	// halted and running are exclusive
	haltedNotRunning: assert property (@(posedge clk) disable iff (!rstN)
		!(halted && run))
		else $error("halted and running both set");

	noStoreWhenStopped: assert property (@(posedge clk) disable iff (!rstN)
		!run |-> !dWe)
		else $error("data memory write enable while stopped");

endmodule

bind cpuTop cpuCore_sva sva0 (.clk, .rstN, .wbCyc, .wbStb, .wbAck, .run, .start,
	.halted(host0.halted), .dWe);

`default_nettype wire

/* sim/cpuTb.sv */
//####################
// cpu testbench
// wishbone host tasks, test programs, isa reference model
//####################
`timescale 1ns/10ps
`default_nettype none

module cpuTb;

	// host map
	localparam logic [9:0] dmemBase = 10'h100;
	localparam logic [9:0] ctrlReg = 10'h200;
	localparam logic [9:0] statReg = 10'h201;
	// wait limits
	localparam int ackTimeout = 16;
	localparam int haltPollLimit = 500;
	localparam int modelStepLimit = 5000;
	// legv8 opcodes
	localparam logic [10:0] addOp = 11'b10001011000;
	localparam logic [10:0] subOp = 11'b11001011000;
	localparam logic [10:0] andOp = 11'b10001010000;
	localparam logic [10:0] orrOp = 11'b10101010000;
	localparam logic [10:0] ldurOp = 11'b11111000010;
	localparam logic [10:0] sturOp = 11'b11111000000;
	localparam logic [9:0] addiOp = 10'b1001000100;
	localparam logic [9:0] subiOp = 10'b1101000100;

	logic clk;
	logic rstN;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic [9:0] wbAdr;
	logic [63:0] wbDatW;
	logic [63:0] wbDatR;
	logic wbAck;

	// reference state that outlives a restart like the dut's registers
	logic [31:0] imemModel [256];
	logic [63:0] dmemModel [256];
	logic [63:0] xModel [32];
	logic [31:0] prog [$];

	cpuTop #(.imemDepth(256), .dmemDepth(256)) dut0 (.clk, .rstN, .wbCyc, .wbStb, .wbWe,
		.wbAdr, .wbDatW, .wbDatR, .wbAck);

	always #20 clk = ~clk;

	task automatic stopRun(input string reason);
		$display("%s", reason);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic valueError(input string msg);
		stopRun($sformatf("FAIL %0t: %s", $time, msg));
	endtask

	// instruction encoders
	function automatic logic [31:0] encR(input logic [10:0] op, input logic [4:0] rm,
		input logic [4:0] rn, input logic [4:0] rd);
		return {op, rm, 6'd0, rn, rd};
	endfunction

	function automatic logic [31:0] encI(input logic [9:0] op, input logic [11:0] imm,
		input logic [4:0] rn, input logic [4:0] rd);
		return {op, imm, rn, rd};
	endfunction

	function automatic logic [31:0] encD(input logic [10:0] op, input logic [8:0] ofs,
		input logic [4:0] rn, input logic [4:0] rt);
		return {op, ofs, 2'b00, rn, rt};
	endfunction

	function automatic logic [31:0] encCbz(input logic [18:0] ofs, input logic [4:0] rt);
		return {8'b10110100, ofs, rt};
	endfunction

	function automatic logic [31:0] encB(input logic [25:0] ofs);
		return {6'b000101, ofs};
	endfunction

	task automatic hostWrite(input logic [9:0] adr, input logic [63:0] dat);
		int waits;
		waits = 0;
		@(posedge clk);
		wbCyc <= 1'b1;
		wbStb <= 1'b1;
		wbWe <= 1'b1;
		wbAdr <= adr;
		wbDatW <= dat;
		do begin
			@(negedge clk);
			waits++;
			if (waits > ackTimeout) begin
				stopRun($sformatf("no wishbone ack for the write to %h", adr));
			end
		end while (!wbAck);
		// ack in the cycle after the strobe
		assert (waits == 2) else valueError($sformatf("write ack after %0d half cycles", waits));
		@(posedge clk);
		wbCyc <= 1'b0;
		wbStb <= 1'b0;
		wbWe <= 1'b0;
	endtask

	task automatic hostRead(input logic [9:0] adr, output logic [63:0] dat);
		int waits;
		waits = 0;
		@(posedge clk);
		wbCyc <= 1'b1;
		wbStb <= 1'b1;
		wbWe <= 1'b0;
		wbAdr <= adr;
		do begin
			@(negedge clk);
			waits++;
			if (waits > ackTimeout) begin
				stopRun($sformatf("no wishbone ack for the read of %h", adr));
			end
		end while (!wbAck);
		assert (waits == 2) else valueError($sformatf("read ack after %0d half cycles", waits));
		dat = wbDatR;
		@(posedge clk);
		wbCyc <= 1'b0;
		wbStb <= 1'b0;
	endtask

	task automatic writeDmem(input int idx, input logic [63:0] val);
		hostWrite(dmemBase + 10'(idx), val);
		dmemModel[idx] = val;
	endtask

	task automatic preloadDmem();
		for (int i = 0; i < 16; i++) begin
			writeDmem(i, {$urandom, $urandom});
		end
	endtask

	task automatic loadProgram();
		foreach (prog[i]) begin
			hostWrite(10'(i), {32'd0, prog[i]});
			imemModel[i] = prog[i];
		end
	endtask

	function automatic logic [63:0] readX(input logic [4:0] idx);
		return (idx == 5'd31) ? 64'd0 : xModel[idx];
	endfunction

	// isa interpreter from address zero to the branch-to-self
	task automatic runModel(output logic [63:0] haltPc);
		logic [63:0] pc;
		logic [31:0] ins;
		logic [63:0] a;
		logic [63:0] adr;
		logic [63:0] res;
		logic wr;
		int steps;
		logic done;
		pc = 64'd0;
		steps = 0;
		done = 1'b0;
		haltPc = 64'd0;
		while (!done) begin
			ins = imemModel[pc[9:2]];
			a = readX(ins[9:5]);
			adr = a + {{55{ins[20]}}, ins[20:12]};
			wr = 1'b1;
			res = 64'd0;
			if (ins[31:26] == 6'b000101) begin
				wr = 1'b0;
				if (ins[25:0] == 26'd0) begin
					done = 1'b1;
					haltPc = pc;
				end else begin
					pc = pc + {{36{ins[25]}}, ins[25:0], 2'b00};
				end
			end else if (ins[31:24] == 8'b10110100) begin
				wr = 1'b0;
				if (readX(ins[4:0]) == 64'd0) begin
					pc = pc + {{43{ins[23]}}, ins[23:5], 2'b00};
				end else begin
					pc = pc + 64'd4;
				end
			end else begin
				if (ins[31:22] == addiOp) begin
					res = a + {52'd0, ins[21:10]};
				end else if (ins[31:22] == subiOp) begin
					res = a - {52'd0, ins[21:10]};
				end else if (ins[31:21] == addOp) begin
					res = a + readX(ins[20:16]);
				end else if (ins[31:21] == subOp) begin
					res = a - readX(ins[20:16]);
				end else if (ins[31:21] == andOp) begin
					res = a & readX(ins[20:16]);
				end else if (ins[31:21] == orrOp) begin
					res = a | readX(ins[20:16]);
				end else if (ins[31:21] == ldurOp) begin
					res = dmemModel[adr[10:3]];
				end else if (ins[31:21] == sturOp) begin
					wr = 1'b0;
					dmemModel[adr[10:3]] = readX(ins[4:0]);
				end else begin
					// anything else is a nop
					wr = 1'b0;
				end
				pc = pc + 64'd4;
			end
			if (wr && ins[4:0] != 5'd31) begin
				xModel[ins[4:0]] = res;
			end
			steps++;
			if (steps > modelStepLimit) begin
				stopRun("reference model never reached a branch-to-self");
			end
		end
	endtask

	task automatic waitHalt();
		logic [63:0] st;
		int polls;
		polls = 0;
		st = 64'd0;
		while (!st[1]) begin
			hostRead(statReg, st);
			polls++;
			if (polls > haltPollLimit) begin
				stopRun("core did not halt within the polling limit");
			end
		end
	endtask

	task automatic compareDmem();
		logic [63:0] d;
		for (int i = 0; i < 16; i++) begin
			hostRead(dmemBase + 10'(i), d);
			assert (d === dmemModel[i])
				else valueError($sformatf("dmem word %0d is %h, expected %h", i, d, dmemModel[i]));
		end
	endtask

	// start, wait for halt, then status and memory against the model
	task automatic runAndCheck();
		logic [63:0] haltPc;
		logic [63:0] st;
		hostWrite(ctrlReg, 64'd1);
		waitHalt();
		runModel(haltPc);
		hostRead(statReg, st);
		assert (st[1:0] == 2'b10) else valueError($sformatf("status bits %b after halt", st[1:0]));
		assert (st[63:32] == haltPc[31:0])
			else valueError($sformatf("halt pc %h, expected %h", st[63:32], haltPc[31:0]));
		compareDmem();
	endtask

	initial begin
		logic [63:0] d;
		logic [63:0] v;
		clk = 1'b0;
		rstN = 1'b0;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = '0;
		wbDatW = '0;
		void'($urandom(52830));
		for (int i = 0; i < 256; i++) begin
			imemModel[i] = 32'd0;
			dmemModel[i] = 64'd0;
		end
		for (int i = 0; i < 32; i++) begin
			xModel[i] = 64'd0;
		end
		repeat (4) @(posedge clk);
		rstN <= 1'b1;

		// host access to both memories
		for (int i = 0; i < 8; i++) begin
			v = {$urandom, $urandom};
			writeDmem(i, v);
			hostRead(dmemBase + 10'(i), d);
			assert (d === v) else valueError($sformatf("dmem readback %h, expected %h", d, v));
			v = {$urandom, $urandom};
			hostWrite(10'(i + 16), v);
			hostRead(10'(i + 16), d);
			assert (d === {32'd0, v[31:0]})
				else valueError($sformatf("imem readback %h, expected %h", d, {32'd0, v[31:0]}));
		end

		// arithmetic on two preloaded operands
		preloadDmem();
		prog = {};
		prog.push_back(encD(ldurOp, 9'd0, 5'd31, 5'd1));
		prog.push_back(encD(ldurOp, 9'd8, 5'd31, 5'd2));
		prog.push_back(encR(addOp, 5'd2, 5'd1, 5'd3));
		prog.push_back(encR(subOp, 5'd2, 5'd1, 5'd4));
		prog.push_back(encR(andOp, 5'd2, 5'd1, 5'd5));
		prog.push_back(encR(orrOp, 5'd2, 5'd1, 5'd6));
		prog.push_back(encI(addiOp, 12'h123, 5'd1, 5'd7));
		prog.push_back(encI(subiOp, 12'h045, 5'd2, 5'd8));
		for (int r = 3; r <= 8; r++) begin
			prog.push_back(encD(sturOp, 9'(r * 8 - 8), 5'd31, 5'(r)));
		end
		prog.push_back(encB(26'd0));
		loadProgram();
		runAndCheck();

		// cbz taken, cbz not taken, b over a store
		preloadDmem();
		prog = {};
		prog.push_back(encI(addiOp, 12'd0, 5'd31, 5'd1));
		prog.push_back(encI(addiOp, 12'd5, 5'd31, 5'd2));
		prog.push_back(encI(addiOp, 12'd0, 5'd31, 5'd3));
		prog.push_back(encCbz(19'd2, 5'd1));
		prog.push_back(encI(addiOp, 12'd1, 5'd3, 5'd3));
		prog.push_back(encCbz(19'd2, 5'd2));
		prog.push_back(encI(addiOp, 12'd16, 5'd3, 5'd3));
		prog.push_back(encI(addiOp, 12'h077, 5'd31, 5'd4));
		prog.push_back(encB(26'd2));
		prog.push_back(encD(sturOp, 9'd8, 5'd31, 5'd4));
		prog.push_back(encD(sturOp, 9'd0, 5'd31, 5'd3));
		prog.push_back(encB(26'd0));
		loadProgram();
		runAndCheck();

		// restart reruns from address zero
		writeDmem(0, {$urandom, $urandom});
		writeDmem(1, {$urandom, $urandom});
		runAndCheck();

		// x31 ignores writes and stores zero
		prog = {};
		prog.push_back(encI(addiOp, 12'd99, 5'd31, 5'd31));
		prog.push_back(encI(addiOp, 12'd7, 5'd31, 5'd5));
		prog.push_back(encD(sturOp, 9'd24, 5'd31, 5'd31));
		prog.push_back(encD(sturOp, 9'd32, 5'd31, 5'd5));
		prog.push_back(encB(26'd0));
		loadProgram();
		runAndCheck();

		// countdown loop keeps the core busy during host accesses
		prog = {};
		prog.push_back(encI(addiOp, 12'd100, 5'd31, 5'd1));
		prog.push_back(encI(subiOp, 12'd1, 5'd1, 5'd1));
		prog.push_back(encCbz(19'd2, 5'd1));
		prog.push_back(encB(26'h3fffffe));
		prog.push_back(encB(26'd0));
		loadProgram();
		hostWrite(ctrlReg, 64'd1);
		hostRead(statReg, d);
		assert (d[1:0] == 2'b01) else valueError($sformatf("status bits %b while running", d[1:0]));
		// write gets dropped so the model keeps its old value
		hostWrite(dmemBase + 10'd3, {$urandom, $urandom});
		// word 4 still holds the 7 stored by the x31 program
		hostRead(dmemBase + 10'd4, d);
		assert (d == 64'd0) else valueError($sformatf("dmem read while running gave %h", d));
		waitHalt();
		compareDmem();

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
hdl/cpuPkg.sv
hdl/programCounter.sv
hdl/controlDecoder.sv
hdl/regFile.sv
hdl/alu.sv
hdl/wordMemory.sv
hdl/cpuCore.sv
hdl/hostRegs.sv
hdl/cpuTop.sv
sim/cpuCore_sva.sv
sim/cpuTb.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run cpuTb and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module cpuTb -o cpuTb
	./obj_dir/cpuTb | tee $(LOG)
	@grep -qx "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
